// File: hdl/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    // load/store funct3 field, size and sign
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    // data memory geometry, in words
    localparam int MEM_AW    = 8;
    localparam int MEM_WORDS = 2 ** MEM_AW;   // 1 KB

    typedef enum logic [1:0] {
        IDLE,   // waiting for execute
        REQ,    // bus transaction open
        WB      // writeback record offered
    } lsu_state_t;

endpackage

// File: hdl/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  lsu_pkg::funct3_t funct3,
    input  logic [1:0]       lane,
    input  lsu_pkg::word_t   sdata,
    output lsu_pkg::word_t   st_wdata,
    output lsu_pkg::strb_t   st_strb
);

    import lsu_pkg::*;

    // data is copied into every lane, the strobe picks the one written
    always_comb begin
        case (funct3)
            F3_B: begin
                st_wdata = {4{sdata[7:0]}};
                st_strb  = strb_t'(4'b0001 << lane);
            end
            F3_H: begin
                st_wdata = {2{sdata[15:0]}};
                st_strb  = strb_t'(4'b0011 << lane);  // lane 0 or 2 only
            end
            F3_W: begin
                st_wdata = sdata;
                st_strb  = 4'b1111;
            end
            default: begin
                st_wdata = sdata;
                st_strb  = 4'b0000;     // no store of that size
            end
        endcase
    end

endmodule

// File: hdl/load_extend.sv
`timescale 1ns/1ps

module load_extend (
    input  lsu_pkg::funct3_t funct3,
    input  logic [1:0]       lane,
    input  lsu_pkg::word_t   rdata,
    output lsu_pkg::word_t   ld_result
);

    import lsu_pkg::*;

    word_t shifted;

    // addressed lane down to bit 0
    assign shifted = rdata >> {lane, 3'b000};

    always_comb begin
        case (funct3)
            F3_B:    ld_result = {{24{shifted[7]}}, shifted[7:0]};
            F3_H:    ld_result = {{16{shifted[15]}}, shifted[15:0]};
            F3_BU:   ld_result = {24'h000000, shifted[7:0]};
            F3_HU:   ld_result = {16'h0000, shifted[15:0]};
            default: ld_result = shifted;   // word, lane is 0
        endcase
    end

endmodule

// File: hdl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
    input  logic           clock,
    input  logic           reset,

    input  lsu_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output lsu_pkg::word_t rdata,
    output logic           rvalid,
    input  logic           rready,

    input  lsu_pkg::addr_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  lsu_pkg::word_t wdata,
    input  lsu_pkg::strb_t wstrb,
    input  logic           wvalid,
    output logic           wready,
    output logic           bvalid,
    input  logic           bready
);

    import lsu_pkg::*;

    word_t             mem [MEM_WORDS];
    logic [MEM_AW-1:0] rd_idx;
    logic [MEM_AW-1:0] wr_idx;
    logic              rd_go;
    logic              wr_go;

    // index wraps at the array size
    assign rd_idx = araddr[MEM_AW+1:2];
    assign wr_idx = awaddr[MEM_AW+1:2];

    assign arready = !rvalid;
    assign rd_go   = arvalid && arready;

    // address and data taken together, one write outstanding
    assign wr_go   = awvalid && wvalid && !bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;

    always_ff @(posedge clock) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_go) begin
            rdata <= mem[rd_idx];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_go) begin
            bvalid <= 1'b1;   // response with the write
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_go) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: hdl/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic               clock,
    input  logic               reset,

    input  logic               in_valid,
    output logic               in_ready,
    input  logic               load,
    input  logic               store,
    input  lsu_pkg::funct3_t   funct3,
    input  lsu_pkg::word_t     alu_res,
    input  lsu_pkg::word_t     sdata,
    input  lsu_pkg::reg_addr_t rd_addr,
    input  logic               wb_en,

    output logic               out_valid,
    input  logic               out_ready,
    output lsu_pkg::word_t     out_result,
    output lsu_pkg::reg_addr_t out_rd_addr,
    output logic               out_wb_en,

    output lsu_pkg::addr_t     araddr,
    output logic               arvalid,
    input  logic               arready,
    input  lsu_pkg::word_t     rdata,
    input  logic               rvalid,
    output logic               rready,
    output lsu_pkg::addr_t     awaddr,
    output logic               awvalid,
    input  logic               awready,
    output lsu_pkg::word_t     wdata,
    output lsu_pkg::strb_t     wstrb,
    output logic               wvalid,
    input  logic               wready,
    input  logic               bvalid,
    output logic               bready,

    output lsu_pkg::funct3_t   op_funct3,
    output logic [1:0]         op_lane,
    output lsu_pkg::word_t     op_sdata,
    input  lsu_pkg::word_t     st_wdata,
    input  lsu_pkg::strb_t     st_strb,
    input  lsu_pkg::word_t     ld_result
);

    import lsu_pkg::*;

    lsu_state_t state, next_state;
    addr_t      op_addr;        // word-aligned bus address
    logic       accept;
    logic       is_load;
    logic       is_store;
    logic       rd_done;
    logic       wr_done;

    assign accept   = in_valid && in_ready;
    assign is_load  = load;
    assign is_store = store && !load;     // load wins if both set
    assign rd_done  = rvalid && rready;
    assign wr_done  = bvalid && bready;

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == WB);
    assign rready    = (state == REQ);
    assign bready    = (state == REQ);

    assign araddr = op_addr;
    assign awaddr = op_addr;
    assign wdata  = st_wdata;
    assign wstrb  = st_strb;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (accept) next_state = (is_load || is_store) ? REQ : WB;
            REQ:  if (rd_done || wr_done) next_state = WB;
            WB:   if (out_ready) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // request valids, each dropped on its own ready
    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            if (accept && is_load) arvalid <= 1'b1;
            else if (arready)      arvalid <= 1'b0;

            if (accept && is_store) awvalid <= 1'b1;
            else if (awready)       awvalid <= 1'b0;

            if (accept && is_store) wvalid <= 1'b1;
            else if (wready)        wvalid <= 1'b0;
        end
    end

    // captured op and writeback record
    always_ff @(posedge clock) begin
        if (accept) begin
            op_funct3   <= funct3;
            op_lane     <= alu_res[1:0];
            op_sdata    <= sdata;
            op_addr     <= {alu_res[31:2], 2'b00};
            out_result  <= alu_res;       // bypass value, stores keep it
            out_rd_addr <= rd_addr;
            out_wb_en   <= wb_en;
        end else if (rd_done) begin
            // word loads skip the extractor
            out_result <= (op_funct3 == F3_W) ? rdata : ld_result;
        end
    end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic               clock,
    input  logic               reset,

    input  logic               in_valid,
    output logic               in_ready,
    input  logic               load,
    input  logic               store,
    input  lsu_pkg::funct3_t   funct3,
    input  lsu_pkg::word_t     alu_res,
    input  lsu_pkg::word_t     sdata,
    input  lsu_pkg::reg_addr_t rd_addr,
    input  logic               wb_en,

    output logic               out_valid,
    input  logic               out_ready,
    output lsu_pkg::word_t     out_result,
    output lsu_pkg::reg_addr_t out_rd_addr,
    output logic               out_wb_en
);

    import lsu_pkg::*;

    // axi-lite to the data memory
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rvalid;
    logic       rready;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;

    // captured op to the aligners and back
    funct3_t    op_funct3;
    logic [1:0] op_lane;
    word_t      op_sdata;
    word_t      st_wdata;
    strb_t      st_strb;
    word_t      ld_result;

    lsu_ctrl u_ctrl (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .load        (load),
        .store       (store),
        .funct3      (funct3),
        .alu_res     (alu_res),
        .sdata       (sdata),
        .rd_addr     (rd_addr),
        .wb_en       (wb_en),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .out_rd_addr (out_rd_addr),
        .out_wb_en   (out_wb_en),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .op_funct3   (op_funct3),
        .op_lane     (op_lane),
        .op_sdata    (op_sdata),
        .st_wdata    (st_wdata),
        .st_strb     (st_strb),
        .ld_result   (ld_result)
    );

    store_align u_store_align (
        .funct3   (op_funct3),
        .lane     (op_lane),
        .sdata    (op_sdata),
        .st_wdata (st_wdata),
        .st_strb  (st_strb)
    );

    load_extend u_load_extend (
        .funct3    (op_funct3),
        .lane      (op_lane),
        .rdata     (rdata),
        .ld_result (ld_result)
    );

    axi_sram u_sram (
        .clock   (clock),
        .reset   (reset),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// File: verif/lsu_assert.sv
`timescale 1ns/1ps

module lsu_assert (
    input logic                clock,
    input logic                reset,
    input lsu_pkg::lsu_state_t state,
    input logic                in_ready,
    input logic                out_valid,
    input logic                out_ready,
    input lsu_pkg::word_t      out_result,
    input logic                arvalid,
    input logic                arready,
    input logic                awvalid,
    input logic                awready,
    input logic                wvalid,
    input logic                wready
);

    import lsu_pkg::*;

    // request valids stay up until taken
    ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    // writeback record frozen under back-pressure
    wb_hold: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else $error("writeback record changed while out_ready was low");

    no_overlap: assert property (@(posedge clock) disable iff (reset)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high together");

    // entering REQ opens a read or a write
    req_open: assert property (@(posedge clock) disable iff (reset)
        $rose(state == REQ) |-> arvalid || (awvalid && wvalid))
        else $error("bus transaction entered without a request");

endmodule

// File: verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    import lsu_pkg::*;

    localparam int    TIMEOUT_CYCLES = 50;
    localparam int    CASE_WORDS     = 512;     // 8 fields per case
    localparam int    SEED           = 76580;
    localparam string CASES_FILE     = "verif/lsu_cases.txt";

    logic      clock = 1'b0;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    logic      load;
    logic      store;
    funct3_t   funct3;
    word_t     alu_res;
    word_t     sdata;
    reg_addr_t rd_addr;
    logic      wb_en;
    logic      out_valid;
    logic      out_ready;
    word_t     out_result;
    reg_addr_t out_rd_addr;
    logic      out_wb_en;

    word_t       case_mem [CASE_WORDS];
    int          errors   = 0;
    int          timeouts = 0;
    int          case_no  = 0;
    int          base;
    logic        stuck;
    logic        found_end;

    always #5 clock = ~clock;

    lsu_top dut0 (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .load        (load),
        .store       (store),
        .funct3      (funct3),
        .alu_res     (alu_res),
        .sdata       (sdata),
        .rd_addr     (rd_addr),
        .wb_en       (wb_en),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .out_rd_addr (out_rd_addr),
        .out_wb_en   (out_wb_en)
    );

    bind lsu_ctrl lsu_assert u_assert (
        .clock      (clock),
        .reset      (reset),
        .state      (state),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .arvalid    (arvalid),
        .arready    (arready),
        .awvalid    (awvalid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wready     (wready)
    );

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h got %h (case %0d)", name, exp, act, case_no);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h got %h (case %0d)", name, exp, act, case_no);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h got %h (case %0d)", name, exp, act, case_no);
        end
    endtask

    // one operation in, one writeback record out
    task automatic run_case(input int b);
        int   n;
        logic held;
        logic done;
        n = 0;
        while (!in_ready && n < TIMEOUT_CYCLES) begin
            @(negedge clock);
            n++;
        end
        if (!in_ready) begin
            timeouts++;
            stuck = 1'b1;
            $display("timeout waiting for in_ready in case %0d", case_no);
            return;
        end
        load     = case_mem[b][0];
        store    = case_mem[b+1][0];
        funct3   = case_mem[b+2][2:0];
        alu_res  = case_mem[b+3];
        sdata    = case_mem[b+4];
        rd_addr  = case_mem[b+5][4:0];
        wb_en    = case_mem[b+6][0];
        in_valid = 1'b1;
        @(negedge clock);
        in_valid = 1'b0;
        check_bit("in_ready", 1'b0, in_ready);    // taken exactly once

        n = 0;
        while (!out_valid && n < TIMEOUT_CYCLES) begin
            out_ready = ($urandom_range(0, 1) == 0);
            @(negedge clock);
            n++;
        end
        if (!out_valid) begin
            timeouts++;
            stuck = 1'b1;
            $display("timeout waiting for out_valid in case %0d", case_no);
            return;
        end
        check_word("out_result", case_mem[b+7], out_result);
        check_reg("out_rd_addr", case_mem[b+5][4:0], out_rd_addr);
        check_bit("out_wb_en", case_mem[b+6][0], out_wb_en);

        // random back-pressure, record must stay put
        n = 0;
        done = 1'b0;
        while (!done && n < TIMEOUT_CYCLES) begin
            out_ready = ($urandom_range(0, 2) == 0);
            held = out_ready;
            @(negedge clock);
            n++;
            if (held) begin
                done = 1'b1;
                check_bit("out_valid", 1'b0, out_valid);
            end else begin
                check_bit("out_valid", 1'b1, out_valid);
                check_word("out_result", case_mem[b+7], out_result);
                check_reg("out_rd_addr", case_mem[b+5][4:0], out_rd_addr);
            end
        end
        out_ready = 1'b0;
        if (!done) begin
            timeouts++;
            stuck = 1'b1;
            $display("timeout waiting for the writeback handshake in case %0d", case_no);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        in_valid  = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        funct3    = F3_W;
        alu_res   = '0;
        sdata     = '0;
        rd_addr   = '0;
        wb_en     = 1'b0;
        out_ready = 1'b0;
        stuck     = 1'b0;
        found_end = 1'b0;
        $readmemh(CASES_FILE, case_mem);

        repeat (4) @(negedge clock);
        reset = 1'b0;
        check_bit("in_ready", 1'b1, in_ready);
        check_bit("out_valid", 1'b0, out_valid);

        base = 0;
        while (!stuck && !found_end && base + 8 <= CASE_WORDS) begin
            if (case_mem[base] == 32'hff) begin
                found_end = 1'b1;
            end else begin
                run_case(base);
                case_no++;
                base += 8;
            end
        end
        if (!found_end && !stuck) begin
            errors++;
            $display("case file has no end marker");
        end

        $display("cases run %0d, errors %0d, timeouts %0d", case_no, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verif/lsu_cases.txt
// load store funct3 alu_res sdata rd_addr wb_en expected
// every field in hex, ff in the load column ends the list
// bypass
0 0 2 12345678 00000000 05 1 12345678
0 0 0 deadbeef 00000000 00 0 deadbeef
// word store, then word load back
0 1 2 00000010 a5a5c3c3 01 0 00000010
1 0 2 00000010 00000000 02 1 a5a5c3c3
// byte stores into each lane of 0x20
0 1 2 00000020 11223344 00 0 00000020
0 1 0 00000020 000000aa 00 0 00000020
0 1 0 00000021 000000bb 00 0 00000021
0 1 0 00000022 0012345c 00 0 00000022
0 1 0 00000023 0000007e 00 0 00000023
1 0 2 00000020 00000000 03 1 7e5cbbaa
// halfword stores at lanes 0 and 2 of 0x30
0 1 2 00000030 cafef00d 00 0 00000030
0 1 1 00000030 ffff1234 00 0 00000030
0 1 1 00000032 00008765 00 0 00000032
1 0 2 00000030 00000000 04 1 87651234
// byte loads, signed then unsigned
1 0 0 00000020 00000000 06 1 ffffffaa
1 0 4 00000020 00000000 07 1 000000aa
1 0 0 00000021 00000000 08 1 ffffffbb
1 0 4 00000021 00000000 09 1 000000bb
1 0 0 00000022 00000000 0a 1 0000005c
1 0 4 00000022 00000000 0b 1 0000005c
1 0 0 00000023 00000000 0c 1 0000007e
1 0 4 00000023 00000000 0d 1 0000007e
1 0 0 00000033 00000000 0e 1 ffffff87
1 0 4 00000033 00000000 0f 1 00000087
1 0 0 00000031 00000000 10 1 00000012
// halfword loads
1 0 1 00000020 00000000 11 1 ffffbbaa
1 0 5 00000020 00000000 12 1 0000bbaa
1 0 1 00000022 00000000 13 1 00007e5c
1 0 5 00000022 00000000 14 1 00007e5c
1 0 1 00000032 00000000 15 1 ffff8765
1 0 5 00000032 00000000 16 1 00008765
1 0 1 00000030 00000000 17 1 00001234
// addresses wrap at 1 KB
0 1 2 00000440 0badf00d 00 0 00000440
1 0 2 00000040 00000000 18 1 0badf00d
0 1 0 00000841 00000099 00 0 00000841
1 0 2 00000040 00000000 19 1 0bad990d
1 0 4 00000c41 00000000 1a 1 00000099
// end of list
ff 0 0 00000000 00000000 00 0 00000000

// File: lsu.f
hdl/lsu_pkg.sv
hdl/store_align.sv
hdl/load_extend.sv
hdl/axi_sram.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
verif/lsu_assert.sv
verif/lsu_tb.sv

// File: Makefile
TOP = lsu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f lsu.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	@if grep -q "FAIL: see errors above" run.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" run.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir run.log
